//--- rtl/uce_cache_pkg.sv
`default_nettype none

package uce_cache_pkg;

  // cache geometry, two ways
  localparam int paddr_width = 32;
  localparam int block_width = 256;
  localparam int fill_width = 64;
  localparam int fill_beats = block_width / fill_width;
  localparam int sets = 16;
  localparam int index_width = $clog2(sets);
  localparam int block_offset_width = $clog2(block_width / 8);
  localparam int tag_width = paddr_width - index_width - block_offset_width;
  localparam int way_width = 1;

  // one-hot mask of the fill beat inside a block
  typedef logic [fill_beats-1:0] fill_index_t;

  typedef enum logic [1:0] {
    e_miss_load,
    e_uc_load,
    e_uc_store
  } req_type_e;

  // size holds log2 of the byte count
  typedef struct packed {
    req_type_e req_type;
    logic [paddr_width-1:0] addr;
    logic [1:0] size;
    logic [way_width-1:0] repl_way;
    logic [fill_width-1:0] data;
  } cache_req_s;

  typedef enum logic {
    e_tag_set_clear,
    e_tag_set_tag
  } tag_op_e;

  typedef struct packed {
    tag_op_e opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0] way_id;
    logic [tag_width-1:0] tag;
  } tag_pkt_s;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_op_e;

  typedef struct packed {
    data_op_e opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0] way_id;
    fill_index_t fill_index;
    logic [fill_width-1:0] data;
  } data_pkt_s;

endpackage

`default_nettype wire

//--- rtl/uce_mem_pkg.sv
`default_nettype none

package uce_mem_pkg;

  localparam int mem_addr_width = 32;
  localparam int mem_data_width = 64;
  localparam int mem_way_width = 1;
  localparam int lce_id_width = 8;

  typedef enum logic [1:0] {
    e_mem_rd,
    e_mem_uc_rd,
    e_mem_uc_wr
  } mem_msg_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    e_mem_size_1  = 3'd0,
    e_mem_size_2  = 3'd1,
    e_mem_size_4  = 3'd2,
    e_mem_size_8  = 3'd3,
    e_mem_size_32 = 3'd5
  } mem_size_e;

  typedef struct packed {
    mem_msg_e msg_type;
    logic [mem_addr_width-1:0] addr;
    mem_size_e size;
    logic [mem_way_width-1:0] way_id;
    logic [lce_id_width-1:0] lce_id;
  } mem_header_s;

endpackage

`default_nettype wire

//--- rtl/uce_req_stage.sv
`timescale 1ns/10ps
`default_nettype none

module uce_req_stage (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire uce_cache_pkg::cache_req_s cache_req_i,
  input  wire                        cache_req_v_i,
  input  wire                        accept_en_i,
  input  wire                        release_i,
  output logic                       cache_req_yumi_o,
  output uce_cache_pkg::cache_req_s  req_o,
  output logic                       req_v_o
);

  // a release in the same cycle frees the slot for the next request
  assign cache_req_yumi_o = cache_req_v_i & accept_en_i & (~req_v_o | release_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req_v_o <= 1'b0;
    else if (cache_req_yumi_o)
      req_v_o <= 1'b1;
    else if (release_i)
      req_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o)
      req_o <= cache_req_i;
  end

endmodule

`default_nettype wire

//--- rtl/uce_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module uce_ctrl #(
  parameter logic [uce_mem_pkg::lce_id_width-1:0] lce_id_p = 8'h2a
) (
  input  wire                                      clk_i,
  input  wire                                      reset_i,
  input  wire uce_cache_pkg::cache_req_s           req_i,
  input  wire                                      req_v_i,
  input  wire                                      cmd_ready_i,
  input  wire                                      credits_full_i,
  input  wire uce_mem_pkg::mem_header_s            fill_hdr_i,
  input  wire [uce_mem_pkg::mem_data_width-1:0]    fill_data_i,
  input  wire uce_cache_pkg::fill_index_t          fill_index_i,
  input  wire                                      fill_last_i,
  input  wire                                      fill_v_i,
  input  wire                                      tag_pkt_yumi_i,
  input  wire                                      data_pkt_yumi_i,
  output logic                                     accept_en_o,
  output logic                                     release_o,
  output uce_mem_pkg::mem_header_s                 cmd_hdr_o,
  output logic [uce_mem_pkg::mem_data_width-1:0]   cmd_data_o,
  output logic                                     cmd_v_o,
  output logic                                     fill_yumi_o,
  output uce_cache_pkg::tag_pkt_s                  tag_pkt_o,
  output logic                                     tag_pkt_v_o,
  output uce_cache_pkg::data_pkt_s                 data_pkt_o,
  output logic                                     data_pkt_v_o,
  output logic                                     busy_o,
  output logic                                     complete_o
);

  localparam int off_w = uce_cache_pkg::block_offset_width;
  localparam int idx_w = uce_cache_pkg::index_width;
  localparam int uc_w = uce_cache_pkg::fill_width / uce_cache_pkg::fill_beats;

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_send,
    e_read_wait,
    e_uc_read_wait
  } state_e;

  state_e state_r, state_n;
  logic [idx_w-1:0] index_r;
  logic tag_sent_r, data_sent_r;
  logic tag_take, data_take, beat_done, clear_take, is_miss, is_store;

  assign is_miss = (req_i.req_type == uce_cache_pkg::e_miss_load);
  assign is_store = req_v_i & (req_i.req_type == uce_cache_pkg::e_uc_store);
  assign tag_take = tag_pkt_v_o & tag_pkt_yumi_i;
  assign data_take = data_pkt_v_o & data_pkt_yumi_i;
  assign clear_take = (state_r == e_clear) & tag_take;
  // a fill beat retires once both its tag and data packets are taken
  assign beat_done = (state_r == e_read_wait) & fill_v_i
                   & (tag_sent_r | tag_take) & (data_sent_r | data_take);
  assign busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_i;

  always_comb
  begin
    state_n = state_r;
    accept_en_o = 1'b0;
    release_o = 1'b0;
    complete_o = 1'b0;
    cmd_hdr_o = '0;
    cmd_hdr_o.lce_id = lce_id_p;
    cmd_data_o = '0;
    cmd_v_o = 1'b0;
    fill_yumi_o = 1'b0;
    tag_pkt_o = '0;
    tag_pkt_v_o = 1'b0;
    data_pkt_o = '0;
    data_pkt_v_o = 1'b0;
    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_pkt_o.opcode = uce_cache_pkg::e_tag_set_clear;
        tag_pkt_o.index = index_r;
        tag_pkt_v_o = 1'b1;
        if (tag_pkt_yumi_i && index_r == idx_w'(uce_cache_pkg::sets - 1))
          state_n = e_ready;
      end
      e_ready:
      begin
        accept_en_o = 1'b1;
        // stores leave straight from here and do not block
        if (is_store)
        begin
          cmd_hdr_o.msg_type = uce_mem_pkg::e_mem_uc_wr;
          cmd_hdr_o.addr = req_i.addr;
          cmd_hdr_o.size = uce_mem_pkg::mem_size_e'({1'b0, req_i.size});
          cmd_data_o = req_i.data;
          cmd_v_o = 1'b1;
          release_o = cmd_ready_i;
        end
        else if (req_v_i)
          state_n = e_send;
      end
      e_send:
      begin
        if (is_miss)
        begin
          cmd_hdr_o.msg_type = uce_mem_pkg::e_mem_rd;
          cmd_hdr_o.addr = {req_i.addr[uce_cache_pkg::paddr_width-1:off_w], {off_w{1'b0}}};
          cmd_hdr_o.size = uce_mem_pkg::e_mem_size_32;
          cmd_hdr_o.way_id = req_i.repl_way;
        end
        else
        begin
          cmd_hdr_o.msg_type = uce_mem_pkg::e_mem_uc_rd;
          cmd_hdr_o.addr = req_i.addr;
          cmd_hdr_o.size = uce_mem_pkg::mem_size_e'({1'b0, req_i.size});
        end
        cmd_v_o = 1'b1;
        if (cmd_ready_i)
          state_n = is_miss ? e_read_wait : e_uc_read_wait;
      end
      e_read_wait:
      begin
        tag_pkt_o.opcode = uce_cache_pkg::e_tag_set_tag;
        tag_pkt_o.index = fill_hdr_i.addr[off_w +: idx_w];
        tag_pkt_o.way_id = fill_hdr_i.way_id;
        tag_pkt_o.tag = fill_hdr_i.addr[off_w + idx_w +: uce_cache_pkg::tag_width];
        tag_pkt_v_o = fill_v_i & ~tag_sent_r;
        data_pkt_o.opcode = uce_cache_pkg::e_data_write;
        data_pkt_o.index = fill_hdr_i.addr[off_w +: idx_w];
        data_pkt_o.way_id = fill_hdr_i.way_id;
        data_pkt_o.fill_index = fill_index_i;
        data_pkt_o.data = fill_data_i;
        data_pkt_v_o = fill_v_i & ~data_sent_r;
        fill_yumi_o = beat_done;
        complete_o = beat_done & fill_last_i;
        release_o = complete_o;
        if (complete_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode = uce_cache_pkg::e_data_uncached;
        data_pkt_o.data = {uce_cache_pkg::fill_beats{fill_data_i[uc_w-1:0]}};
        data_pkt_v_o = fill_v_i;
        fill_yumi_o = data_take;
        complete_o = data_take;
        release_o = data_take;
        if (data_take)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      index_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (clear_take)
        index_r <= index_r + 1'b1;
    end
  end

  // remembers which half of a fill beat the cache already took
  always_ff @(posedge clk_i)
  begin
    if (reset_i || beat_done)
    begin
      tag_sent_r <= 1'b0;
      data_sent_r <= 1'b0;
    end
    else if (state_r == e_read_wait)
    begin
      tag_sent_r <= tag_sent_r | tag_take;
      data_sent_r <= data_sent_r | data_take;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uce_cmd_port.sv
`timescale 1ns/10ps
`default_nettype none

module uce_cmd_port #(
  parameter int credits_p = 4
) (
  input  wire                                    clk_i,
  input  wire                                    reset_i,
  input  wire uce_mem_pkg::mem_header_s          cmd_hdr_i,
  input  wire [uce_mem_pkg::mem_data_width-1:0]  cmd_data_i,
  input  wire                                    cmd_v_i,
  input  wire                                    mem_cmd_ready_and_i,
  input  wire                                    resp_done_i,
  output logic                                   cmd_ready_o,
  output uce_mem_pkg::mem_header_s               mem_cmd_header_o,
  output logic [uce_mem_pkg::mem_data_width-1:0] mem_cmd_data_o,
  output logic                                   mem_cmd_v_o,
  output logic                                   credits_full_o,
  output logic                                   credits_empty_o
);

  localparam int cnt_w = $clog2(credits_p + 1);

  logic full_r, send, load;
  logic [cnt_w-1:0] credit_r;

  assign credits_full_o = (credit_r == cnt_w'(credits_p));
  assign credits_empty_o = (credit_r == '0);
  // held command stays off the network while no credit is left
  assign mem_cmd_v_o = full_r & ~credits_full_o;
  assign send = mem_cmd_v_o & mem_cmd_ready_and_i;
  assign cmd_ready_o = (~full_r | send) & ~credits_full_o;
  assign load = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      full_r <= 1'b0;
    else if (load)
      full_r <= 1'b1;
    else if (send)
      full_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      mem_cmd_header_o <= cmd_hdr_i;
      mem_cmd_data_o <= cmd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credit_r <= '0;
    else if (send && !resp_done_i)
      credit_r <= credit_r + 1'b1;
    else if (!send && resp_done_i)
      credit_r <= credit_r - 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/uce_fill_stage.sv
`timescale 1ns/10ps
`default_nettype none

module uce_fill_stage (
  input  wire                                    clk_i,
  input  wire                                    reset_i,
  input  wire uce_mem_pkg::mem_header_s          mem_resp_header_i,
  input  wire [uce_mem_pkg::mem_data_width-1:0]  mem_resp_data_i,
  input  wire                                    mem_resp_v_i,
  input  wire                                    fill_yumi_i,
  output logic                                   mem_resp_ready_and_o,
  output uce_mem_pkg::mem_header_s               fill_hdr_o,
  output logic [uce_mem_pkg::mem_data_width-1:0] fill_data_o,
  output uce_cache_pkg::fill_index_t             fill_index_o,
  output logic                                   fill_last_o,
  output logic                                   fill_v_o,
  output logic                                   resp_done_o
);

  localparam int cnt_w = $clog2(uce_cache_pkg::fill_beats);
  // lowest address bit that selects a fill beat
  localparam int sel_lsb = $clog2(uce_cache_pkg::fill_width / 8);

  logic [cnt_w-1:0] cnt_r, beat_sel;
  logic is_store, is_block, xfer;

  assign is_store = (mem_resp_header_i.msg_type == uce_mem_pkg::e_mem_uc_wr);
  assign is_block = (mem_resp_header_i.size == uce_mem_pkg::e_mem_size_32);
  assign beat_sel = mem_resp_header_i.addr[sel_lsb +: cnt_w];

  assign fill_hdr_o = mem_resp_header_i;
  assign fill_data_o = mem_resp_data_i;
  assign fill_index_o = uce_cache_pkg::fill_index_t'(1) << beat_sel;
  assign fill_last_o = ~is_block | (cnt_r == cnt_w'(uce_cache_pkg::fill_beats - 1));
  // store acks carry no data for the cache
  assign fill_v_o = mem_resp_v_i & ~is_store;
  assign mem_resp_ready_and_o = (mem_resp_v_i & is_store) | fill_yumi_i;
  assign xfer = mem_resp_v_i & mem_resp_ready_and_o;
  assign resp_done_o = xfer & fill_last_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cnt_r <= '0;
    else if (xfer)
      cnt_r <= fill_last_o ? '0 : cnt_r + 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/uce_top.sv
`timescale 1ns/10ps
`default_nettype none

module uce_top #(
  parameter int credits_p = 4,
  parameter logic [uce_mem_pkg::lce_id_width-1:0] lce_id_p = 8'h2a
) (
  input  wire                                    clk_i,
  input  wire                                    reset_i,
  input  wire uce_cache_pkg::cache_req_s         cache_req_i,
  input  wire                                    cache_req_v_i,
  output logic                                   cache_req_yumi_o,
  output logic                                   cache_req_busy_o,
  output logic                                   cache_req_complete_o,
  output uce_cache_pkg::tag_pkt_s                tag_pkt_o,
  output logic                                   tag_pkt_v_o,
  input  wire                                    tag_pkt_yumi_i,
  output uce_cache_pkg::data_pkt_s               data_pkt_o,
  output logic                                   data_pkt_v_o,
  input  wire                                    data_pkt_yumi_i,
  output uce_mem_pkg::mem_header_s               mem_cmd_header_o,
  output logic [uce_mem_pkg::mem_data_width-1:0] mem_cmd_data_o,
  output logic                                   mem_cmd_v_o,
  input  wire                                    mem_cmd_ready_and_i,
  input  wire uce_mem_pkg::mem_header_s          mem_resp_header_i,
  input  wire [uce_mem_pkg::mem_data_width-1:0]  mem_resp_data_i,
  input  wire                                    mem_resp_v_i,
  output logic                                   mem_resp_ready_and_o
);

  uce_cache_pkg::cache_req_s req;
  uce_mem_pkg::mem_header_s cmd_hdr, fill_hdr;
  logic [uce_mem_pkg::mem_data_width-1:0] cmd_data, fill_data;
  uce_cache_pkg::fill_index_t fill_index;
  logic req_v, accept_en, req_release, cmd_v, cmd_ready, credits_full;
  logic fill_last, fill_v, fill_yumi, resp_done;

  uce_req_stage u_req_stage (
    .clk_i(clk_i), .reset_i(reset_i),
    .cache_req_i(cache_req_i), .cache_req_v_i(cache_req_v_i),
    .accept_en_i(accept_en), .release_i(req_release),
    .cache_req_yumi_o(cache_req_yumi_o), .req_o(req), .req_v_o(req_v)
  );

  uce_ctrl #(.lce_id_p(lce_id_p)) u_ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(req), .req_v_i(req_v),
    .cmd_ready_i(cmd_ready), .credits_full_i(credits_full),
    .fill_hdr_i(fill_hdr), .fill_data_i(fill_data), .fill_index_i(fill_index),
    .fill_last_i(fill_last), .fill_v_i(fill_v),
    .tag_pkt_yumi_i(tag_pkt_yumi_i), .data_pkt_yumi_i(data_pkt_yumi_i),
    .accept_en_o(accept_en), .release_o(req_release),
    .cmd_hdr_o(cmd_hdr), .cmd_data_o(cmd_data), .cmd_v_o(cmd_v),
    .fill_yumi_o(fill_yumi),
    .tag_pkt_o(tag_pkt_o), .tag_pkt_v_o(tag_pkt_v_o),
    .data_pkt_o(data_pkt_o), .data_pkt_v_o(data_pkt_v_o),
    .busy_o(cache_req_busy_o), .complete_o(cache_req_complete_o)
  );

  // nothing in this engine waits for the credits to drain
  uce_cmd_port #(.credits_p(credits_p)) u_cmd_port (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_hdr_i(cmd_hdr), .cmd_data_i(cmd_data), .cmd_v_i(cmd_v),
    .mem_cmd_ready_and_i(mem_cmd_ready_and_i), .resp_done_i(resp_done),
    .cmd_ready_o(cmd_ready),
    .mem_cmd_header_o(mem_cmd_header_o), .mem_cmd_data_o(mem_cmd_data_o),
    .mem_cmd_v_o(mem_cmd_v_o),
    .credits_full_o(credits_full), .credits_empty_o()
  );

  uce_fill_stage u_fill_stage (
    .clk_i(clk_i), .reset_i(reset_i),
    .mem_resp_header_i(mem_resp_header_i), .mem_resp_data_i(mem_resp_data_i),
    .mem_resp_v_i(mem_resp_v_i), .fill_yumi_i(fill_yumi),
    .mem_resp_ready_and_o(mem_resp_ready_and_o),
    .fill_hdr_o(fill_hdr), .fill_data_o(fill_data), .fill_index_o(fill_index),
    .fill_last_o(fill_last), .fill_v_o(fill_v), .resp_done_o(resp_done)
  );

endmodule

`default_nettype wire

//--- bench/uce_checker.sv
`timescale 1ns/10ps
`default_nettype none

module uce_checker #(
  parameter int credits_p = 4,
  parameter logic [7:0] lce_id_p = 8'h2a
) (
  input  wire                            clk_i,
  input  wire                            reset_i,
  input  wire uce_cache_pkg::cache_req_s req_i,
  input  wire                            req_v_i,
  input  wire                            req_yumi_i,
  input  wire                            busy_i,
  input  wire                            complete_i,
  input  wire uce_cache_pkg::tag_pkt_s   tag_pkt_i,
  input  wire                            tag_v_i,
  input  wire                            tag_yumi_i,
  input  wire uce_cache_pkg::data_pkt_s  data_pkt_i,
  input  wire                            data_v_i,
  input  wire                            data_yumi_i,
  input  wire uce_mem_pkg::mem_header_s  cmd_hdr_i,
  input  wire [63:0]                     cmd_data_i,
  input  wire                            cmd_v_i,
  input  wire                            cmd_ready_i,
  input  wire uce_mem_pkg::mem_header_s  resp_hdr_i,
  input  wire                            resp_v_i,
  input  wire                            resp_ready_i,
  input  wire                            done_i,
  output int                             error_count_o
);

  localparam int num_tests = 5;

  int checks [num_tests];
  int errors [num_tests];
  int error_total = 0;
  // accepted requests waiting for their command and loads waiting for completion
  uce_cache_pkg::cache_req_s cmd_q[$];
  uce_cache_pkg::cache_req_s load_q[$];
  int clear_cnt = 0;
  int tag_cnt = 0;
  int data_cnt = 0;
  int outstanding = 0;
  int resp_beats = 0;
  int loads = 0;
  int completes = 0;
  logic reported = 1'b0;

  assign error_count_o = error_total;

  function automatic string test_name(input int t);
    case (t)
      0: return "clear sweep";
      1: return "miss load";
      2: return "uncached load";
      3: return "uncached store";
      default: return "credits";
    endcase
  endfunction

  function automatic int test_of(input uce_cache_pkg::cache_req_s r);
    case (r.req_type)
      uce_cache_pkg::e_miss_load: return 1;
      uce_cache_pkg::e_uc_load: return 2;
      default: return 3;
    endcase
  endfunction

  function automatic logic [63:0] mem_word(input logic [31:0] addr);
    logic [31:0] mixed;
    mixed = addr * 32'h9e37_79b9;
    return {mixed, mixed};
  endfunction

  function automatic uce_mem_pkg::mem_header_s cmd_for(input uce_cache_pkg::cache_req_s r);
    uce_mem_pkg::mem_header_s h;
    h = '0;
    h.lce_id = lce_id_p;
    h.addr = r.addr;
    h.size = uce_mem_pkg::mem_size_e'({1'b0, r.size});
    case (r.req_type)
      uce_cache_pkg::e_miss_load:
      begin
        h.msg_type = uce_mem_pkg::e_mem_rd;
        h.addr = {r.addr[31:5], 5'b0};
        h.size = uce_mem_pkg::e_mem_size_32;
        h.way_id = r.repl_way;
      end
      uce_cache_pkg::e_uc_load:
        h.msg_type = uce_mem_pkg::e_mem_uc_rd;
      default:
        h.msg_type = uce_mem_pkg::e_mem_uc_wr;
    endcase
    return h;
  endfunction

  task automatic check_value(input int test, input string name,
                             input logic [127:0] exp, input logic [127:0] got);
    checks[test] = checks[test] + 1;
    if (exp !== got)
    begin
      $display("ERROR %s expected %0h got %0h at %0t", name, exp, got, $time);
      errors[test] = errors[test] + 1;
      error_total = error_total + 1;
    end
  endtask

  task automatic flag_error(input int test, input string what);
    $display("%s at %0t", what, $time);
    errors[test] = errors[test] + 1;
    error_total = error_total + 1;
  endtask

  task automatic check_command();
    uce_cache_pkg::cache_req_s r;
    outstanding = outstanding + 1;
    if (cmd_q.size() == 0)
      flag_error(4, "memory command sent with no accepted request waiting");
    else
    begin
      r = cmd_q.pop_front();
      check_value(test_of(r), "mem_cmd_header_o", cmd_for(r), cmd_hdr_i);
      if (r.req_type == uce_cache_pkg::e_uc_store)
        check_value(3, "mem_cmd_data_o", r.data, cmd_data_i);
    end
  endtask

  task automatic check_tag();
    uce_cache_pkg::tag_pkt_s exp;
    exp = '0;
    if (clear_cnt < uce_cache_pkg::sets)
    begin
      exp.opcode = uce_cache_pkg::e_tag_set_clear;
      exp.index = clear_cnt[3:0];
      check_value(0, "tag_pkt_o", {exp.opcode, exp.index}, {tag_pkt_i.opcode, tag_pkt_i.index});
      clear_cnt = clear_cnt + 1;
      if (clear_cnt == uce_cache_pkg::sets)
        $display("test clear sweep done: %0d checks, %0d errors", checks[0], errors[0]);
    end
    else if (load_q.size() == 0 || load_q[0].req_type != uce_cache_pkg::e_miss_load)
      flag_error(1, "tag packet taken with no miss load in progress");
    else
    begin
      exp.opcode = uce_cache_pkg::e_tag_set_tag;
      exp.index = load_q[0].addr[8:5];
      exp.way_id = load_q[0].repl_way;
      exp.tag = load_q[0].addr[31:9];
      check_value(1, "tag_pkt_o", exp, tag_pkt_i);
      tag_cnt = tag_cnt + 1;
    end
  endtask

  task automatic check_data();
    uce_cache_pkg::data_pkt_s exp;
    uce_cache_pkg::cache_req_s r;
    logic [63:0] word;
    exp = '0;
    if (load_q.size() == 0)
      flag_error(2, "data packet taken with no load in progress");
    else
    begin
      r = load_q[0];
      if (r.req_type == uce_cache_pkg::e_miss_load)
      begin
        exp.opcode = uce_cache_pkg::e_data_write;
        exp.index = r.addr[8:5];
        exp.way_id = r.repl_way;
        exp.fill_index = 4'b0001 << data_cnt;
        exp.data = mem_word({r.addr[31:5], 5'b0} + 32'(8 * data_cnt));
        check_value(1, "data_pkt_o", exp, data_pkt_i);
      end
      else
      begin
        word = mem_word(r.addr);
        exp.opcode = uce_cache_pkg::e_data_uncached;
        exp.data = {4{word[15:0]}};
        check_value(2, "data_pkt_o", {exp.opcode, exp.data}, {data_pkt_i.opcode, data_pkt_i.data});
      end
      data_cnt = data_cnt + 1;
    end
  endtask

  task automatic check_complete();
    logic miss;
    if (load_q.size() == 0)
      flag_error(3, "complete pulse with no load in progress");
    else
    begin
      miss = (load_q[0].req_type == uce_cache_pkg::e_miss_load);
      check_value(test_of(load_q[0]), "data_pkt_o count", miss ? 4 : 1, data_cnt);
      check_value(test_of(load_q[0]), "tag_pkt_o count", miss ? 4 : 0, tag_cnt);
      load_q.delete(0);
      data_cnt = 0;
      tag_cnt = 0;
      completes = completes + 1;
    end
  endtask

  task automatic final_report();
    int t;
    int total_checks;
    total_checks = 0;
    reported = 1'b1;
    if (cmd_q.size() != 0 || load_q.size() != 0)
      flag_error(4, "requests left without a command or completion at the end");
    if (outstanding != 0)
      flag_error(4, "commands still without a response at the end");
    if (clear_cnt != uce_cache_pkg::sets)
      flag_error(0, "clear sweep did not send all of its packets");
    check_value(3, "cache_req_complete_o count", loads, completes);
    for (t = 1; t < num_tests; t = t + 1)
      $display("test %s done: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
    for (t = 0; t < num_tests; t = t + 1)
      total_checks = total_checks + checks[t];
    $display("checks %0d, errors %0d", total_checks, error_total);
  endtask

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (outstanding == credits_p && !busy_i)
        flag_error(4, "busy low while all credits are in use");
      // the cache may not offer requests until the sweep is over
      if (clear_cnt < uce_cache_pkg::sets && !busy_i)
        flag_error(0, "busy low before the clear sweep ended");
      if (req_v_i && req_yumi_i)
      begin
        cmd_q.push_back(req_i);
        if (req_i.req_type != uce_cache_pkg::e_uc_store)
        begin
          load_q.push_back(req_i);
          loads = loads + 1;
        end
      end
      if (cmd_v_i && cmd_ready_i)
        check_command();
      if (tag_v_i && tag_yumi_i)
        check_tag();
      if (data_v_i && data_yumi_i)
        check_data();
      if (complete_i)
        check_complete();
      // a block read answers with four beats and everything else with one
      if (resp_v_i && resp_ready_i)
      begin
        resp_beats = resp_beats + 1;
        if (resp_hdr_i.msg_type != uce_mem_pkg::e_mem_rd || resp_beats == 4)
        begin
          resp_beats = 0;
          outstanding = outstanding - 1;
        end
      end
      if (outstanding > credits_p)
        flag_error(4, "more commands outstanding than credits allow");
      if (done_i && !reported)
        final_report();
    end
  end

endmodule

`default_nettype wire

//--- bench/uce_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uce_tb;

  localparam int num_reqs = 200;
  localparam int timeout_cycles = num_reqs * 60 + 400;

  logic clk_i;
  logic reset_i;
  uce_cache_pkg::cache_req_s cache_req_i;
  logic cache_req_v_i, cache_req_yumi_o, cache_req_busy_o, cache_req_complete_o;
  uce_cache_pkg::tag_pkt_s tag_pkt_o;
  logic tag_pkt_v_o, tag_pkt_yumi_i;
  uce_cache_pkg::data_pkt_s data_pkt_o;
  logic data_pkt_v_o, data_pkt_yumi_i;
  uce_mem_pkg::mem_header_s mem_cmd_header_o, mem_resp_header_i;
  logic [63:0] mem_cmd_data_o, mem_resp_data_i;
  logic mem_cmd_v_o, mem_cmd_ready_and_i, mem_resp_v_i, mem_resp_ready_and_o;

  integer seed = 32'he638_4d1f;
  int issued = 0;
  int msgs_done = 0;
  int cycles = 0;
  int beat = 0;
  int delay = 0;
  int error_count;
  logic run_done = 1'b0;
  // commands taken by memory, answered in order
  uce_mem_pkg::mem_header_s pending_q[$];

  uce_top u_uce_top (
    .clk_i(clk_i), .reset_i(reset_i),
    .cache_req_i(cache_req_i), .cache_req_v_i(cache_req_v_i),
    .cache_req_yumi_o(cache_req_yumi_o), .cache_req_busy_o(cache_req_busy_o),
    .cache_req_complete_o(cache_req_complete_o),
    .tag_pkt_o(tag_pkt_o), .tag_pkt_v_o(tag_pkt_v_o), .tag_pkt_yumi_i(tag_pkt_yumi_i),
    .data_pkt_o(data_pkt_o), .data_pkt_v_o(data_pkt_v_o), .data_pkt_yumi_i(data_pkt_yumi_i),
    .mem_cmd_header_o(mem_cmd_header_o), .mem_cmd_data_o(mem_cmd_data_o),
    .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_ready_and_i(mem_cmd_ready_and_i),
    .mem_resp_header_i(mem_resp_header_i), .mem_resp_data_i(mem_resp_data_i),
    .mem_resp_v_i(mem_resp_v_i), .mem_resp_ready_and_o(mem_resp_ready_and_o)
  );

  uce_checker u_checker (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(cache_req_i), .req_v_i(cache_req_v_i), .req_yumi_i(cache_req_yumi_o),
    .busy_i(cache_req_busy_o), .complete_i(cache_req_complete_o),
    .tag_pkt_i(tag_pkt_o), .tag_v_i(tag_pkt_v_o), .tag_yumi_i(tag_pkt_yumi_i),
    .data_pkt_i(data_pkt_o), .data_v_i(data_pkt_v_o), .data_yumi_i(data_pkt_yumi_i),
    .cmd_hdr_i(mem_cmd_header_o), .cmd_data_i(mem_cmd_data_o),
    .cmd_v_i(mem_cmd_v_o), .cmd_ready_i(mem_cmd_ready_and_i),
    .resp_hdr_i(mem_resp_header_i), .resp_v_i(mem_resp_v_i),
    .resp_ready_i(mem_resp_ready_and_o),
    .done_i(run_done), .error_count_o(error_count)
  );

  // memory contents follow the address, same word in both halves
  function automatic logic [63:0] mem_word(input logic [31:0] addr);
    logic [31:0] mixed;
    mixed = addr * 32'h9e37_79b9;
    return {mixed, mixed};
  endfunction

  task automatic new_request();
    uce_cache_pkg::cache_req_s req;
    int pick;
    pick = $unsigned($random(seed)) % 10;
    req.req_type = (pick < 4) ? uce_cache_pkg::e_miss_load
                 : (pick < 7) ? uce_cache_pkg::e_uc_load : uce_cache_pkg::e_uc_store;
    req.addr = $random(seed);
    req.size = 2'($random(seed));
    req.repl_way = 1'($random(seed));
    req.data = {$random(seed), $random(seed)};
    cache_req_i <= req;
    cache_req_v_i <= 1'b1;
  endtask

  task automatic drive_beat(input uce_mem_pkg::mem_header_s cmd, input int n);
    uce_mem_pkg::mem_header_s hdr;
    hdr = cmd;
    hdr.addr = cmd.addr + 32'(8 * n);
    mem_resp_header_i <= hdr;
    mem_resp_data_i <= (cmd.msg_type == uce_mem_pkg::e_mem_uc_wr) ? 64'h0 : mem_word(hdr.addr);
    mem_resp_v_i <= 1'b1;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial
  begin
    reset_i = 1'b1;
    cache_req_i = '0;
    cache_req_v_i = 1'b0;
    tag_pkt_yumi_i = 1'b0;
    data_pkt_yumi_i = 1'b0;
    mem_cmd_ready_and_i = 1'b0;
    mem_resp_header_i = '0;
    mem_resp_data_i = '0;
    mem_resp_v_i = 1'b0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    while (msgs_done < num_reqs)
      @(posedge clk_i);
    run_done <= 1'b1;
    repeat (3) @(posedge clk_i);
    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  always @(posedge clk_i)
  begin
    mem_cmd_ready_and_i <= ($random(seed) % 4) != 0;
    tag_pkt_yumi_i <= ($random(seed) % 3) != 0;
    data_pkt_yumi_i <= ($random(seed) % 3) != 0;
    // cache side, valid only offered while the engine is not busy
    if (cache_req_v_i && cache_req_yumi_o)
    begin
      issued = issued + 1;
      cache_req_v_i <= 1'b0;
    end
    else if (cache_req_v_i && cache_req_busy_o)
      cache_req_v_i <= 1'b0;
    if (!reset_i && !cache_req_busy_o && issued < num_reqs
        && (!cache_req_v_i || cache_req_yumi_o) && ($random(seed) % 4) != 0)
      new_request();
    // memory side
    if (mem_cmd_v_o && mem_cmd_ready_and_i)
      pending_q.push_back(mem_cmd_header_o);
    if (mem_resp_v_i && mem_resp_ready_and_o)
    begin
      if (beat + 1 == ((pending_q[0].msg_type == uce_mem_pkg::e_mem_rd) ? 4 : 1))
      begin
        pending_q.delete(0);
        mem_resp_v_i <= 1'b0;
        msgs_done <= msgs_done + 1;
        beat = 0;
        delay = $unsigned($random(seed)) % 8;
      end
      else
      begin
        beat = beat + 1;
        drive_beat(pending_q[0], beat);
      end
    end
    else if (!mem_resp_v_i && pending_q.size() > 0)
    begin
      if (delay > 0)
        delay = delay - 1;
      else
        drive_beat(pending_q[0], 0);
    end
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, %0d of %0d responses done",
               cycles, msgs_done, num_reqs);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/uce_cache_pkg.sv
rtl/uce_mem_pkg.sv
rtl/uce_req_stage.sv
rtl/uce_ctrl.sv
rtl/uce_cmd_port.sv
rtl/uce_fill_stage.sv
rtl/uce_top.sv
bench/uce_checker.sv
bench/uce_tb.sv

//--- Bender.yml
package:
  name: uce

sources:
  - rtl/uce_cache_pkg.sv
  - rtl/uce_mem_pkg.sv
  - rtl/uce_req_stage.sv
  - rtl/uce_ctrl.sv
  - rtl/uce_cmd_port.sv
  - rtl/uce_fill_stage.sv
  - rtl/uce_top.sv
  - target: simulation
    files:
      - bench/uce_checker.sv
      - bench/uce_tb.sv
